/* btb_pkg.sv */
`default_nettype none

package btb_pkg;

    // geometry of the direct-mapped table
    localparam int ENTRIES          = 64;
    localparam int INDEX_W          = 6;   // eip[5:0]
    localparam int TAG_W            = 26;  // eip[31:6]
    localparam int FIP_W            = 28;  // upper bits of a fetch-line address

    // queue depths and credits
    localparam int REQ_QUEUE_DEPTH  = 4;   // also the fetch unit's credits after reset
    localparam int PRED_QUEUE_DEPTH = 4;
    localparam int PRED_CREDITS     = 2;

    typedef logic [31:0]        eip_t;
    typedef logic [FIP_W-1:0]   fip_t;
    typedef logic [INDEX_W-1:0] btb_index_t;
    typedef logic [TAG_W-1:0]   btb_tag_t;

    // queue bookkeeping
    typedef logic [$clog2(REQ_QUEUE_DEPTH)-1:0]    req_ptr_t;
    typedef logic [$clog2(REQ_QUEUE_DEPTH+1)-1:0]  req_cnt_t;
    typedef logic [$clog2(PRED_QUEUE_DEPTH)-1:0]   pred_ptr_t;
    typedef logic [$clog2(PRED_QUEUE_DEPTH+1)-1:0] pred_cnt_t;
    typedef logic [$clog2(PRED_CREDITS+1)-1:0]     pred_cred_t;

    // lookup request from fetch
    typedef struct packed {
        eip_t eip;
    } btb_req_t;

    // update from write-back, full 32-bit pointers
    typedef struct packed {
        eip_t eip;
        eip_t target;
        eip_t fip_e;
        eip_t fip_o;
    } btb_update_t;

    // one table entry, 115 bits
    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        eip_t     target;
        fip_t     fip_e;
        fip_t     fip_o;
    } btb_entry_t;

    // prediction returned to fetch, 89 bits
    typedef struct packed {
        logic hit;
        eip_t target;
        fip_t fip_e;
        fip_t fip_o;
    } btb_pred_t;

endpackage

`default_nettype wire

/* btb_req_queue.sv */
`default_nettype none
`timescale 1ns/1ps

module btb_req_queue (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  btb_pkg::btb_req_t req,
    input  logic              slot_free,
    output logic              issue_valid,
    output btb_pkg::btb_req_t issue_req,
    output logic              req_credit
);

    btb_pkg::btb_req_t mem [btb_pkg::REQ_QUEUE_DEPTH];  // request storage
    btb_pkg::req_ptr_t wr_ptr;
    btb_pkg::req_ptr_t rd_ptr;
    btb_pkg::req_cnt_t count;
    logic              empty;
    logic              full;

    assign empty = (count == '0);
    assign full  = (count == btb_pkg::req_cnt_t'(btb_pkg::REQ_QUEUE_DEPTH));

    // head goes to the array as soon as the output side has room for its answer
    assign issue_valid = !empty && slot_free;
    assign issue_req   = mem[rd_ptr];
    assign req_credit  = issue_valid;  // one credit back per issued entry

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the power-of-two depth
            end
            if (issue_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    // fetch may only send while holding a credit, so a full queue never sees a push
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        req_valid |-> !full
    ) else $error("request pushed into a full queue, sender overran its credits");

endmodule

`default_nettype wire

/* btb_array.sv */
`default_nettype none
`timescale 1ns/1ps

module btb_array (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 upd_valid,
    input  btb_pkg::btb_update_t upd,
    input  logic                 issue_valid,
    input  btb_pkg::btb_req_t    issue_req,
    output logic                 lookup_valid,
    output btb_pkg::btb_pred_t   lookup_pred
);

    btb_pkg::btb_entry_t entries [btb_pkg::ENTRIES];

    btb_pkg::btb_index_t upd_index;
    btb_pkg::btb_tag_t   upd_tag;
    btb_pkg::btb_entry_t upd_entry;
    btb_pkg::btb_index_t lk_index;
    btb_pkg::btb_tag_t   lk_tag;
    btb_pkg::btb_entry_t rd_entry;
    logic                rd_hit;

    // split both eips into index and tag
    assign upd_index = upd.eip[btb_pkg::INDEX_W-1:0];
    assign upd_tag   = upd.eip[31:btb_pkg::INDEX_W];
    assign lk_index  = issue_req.eip[btb_pkg::INDEX_W-1:0];
    assign lk_tag    = issue_req.eip[31:btb_pkg::INDEX_W];

    // new entry from write-back, only the upper pointer bits are stored
    always_comb begin
        upd_entry.valid  = 1'b1;
        upd_entry.tag    = upd_tag;
        upd_entry.target = upd.target;
        upd_entry.fip_e  = upd.fip_e[31:32-btb_pkg::FIP_W];
        upd_entry.fip_o  = upd.fip_o[31:32-btb_pkg::FIP_W];
    end

    // direct mapped, a single entry can hit
    assign rd_entry = entries[lk_index];
    assign rd_hit   = rd_entry.valid && (rd_entry.tag == lk_tag);

    // table write, reset only clears the valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < btb_pkg::ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (upd_valid) begin
            entries[upd_index] <= upd_entry;  // overwrite whatever lived at this index
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= issue_valid;
        end
    end

    // registered lookup result, payload zeroed on a miss
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            lookup_pred.hit    <= rd_hit;
            lookup_pred.target <= rd_hit ? rd_entry.target : '0;
            lookup_pred.fip_e  <= rd_hit ? rd_entry.fip_e : '0;
            lookup_pred.fip_o  <= rd_hit ? rd_entry.fip_o : '0;
        end
    end

    // output side counts on the answer arriving exactly one cycle after issue
    a_lookup_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        lookup_valid == $past(issue_valid)
    ) else $error("lookup result not one cycle after issue");

endmodule

`default_nettype wire

/* btb_pred_out.sv */
`default_nettype none
`timescale 1ns/1ps

module btb_pred_out (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               issue_valid,
    input  logic               lookup_valid,
    input  btb_pkg::btb_pred_t lookup_pred,
    output logic               slot_free,
    output logic               pred_valid,
    output btb_pkg::btb_pred_t pred,
    input  logic               pred_credit
);

    btb_pkg::btb_pred_t  mem [btb_pkg::PRED_QUEUE_DEPTH];
    btb_pkg::pred_ptr_t  wr_ptr;
    btb_pkg::pred_ptr_t  rd_ptr;
    btb_pkg::pred_cnt_t  count;
    btb_pkg::pred_cnt_t  resv;   // lookups in flight, each owns a slot
    btb_pkg::pred_cred_t cred;   // downstream credits on hand

    // room for one more lookup only if queued plus in-flight leaves a slot
    assign slot_free  = (int'(count) + int'(resv)) < btb_pkg::PRED_QUEUE_DEPTH;
    assign pred_valid = (count != '0) && (cred != '0);
    assign pred       = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            resv   <= '0;
            cred   <= btb_pkg::pred_cred_t'(btb_pkg::PRED_CREDITS);
        end else begin
            if (lookup_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pred_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // reservation becomes a queue entry when the lookup lands
            case ({issue_valid, lookup_valid})
                2'b10:   resv <= resv + 1'b1;
                2'b01:   resv <= resv - 1'b1;
                default: resv <= resv;
            endcase
            case ({lookup_valid, pred_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pred_credit, pred_valid})
                2'b10:   cred <= cred + 1'b1;
                2'b01:   cred <= cred - 1'b1;  // spent on a send
                default: cred <= cred;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            mem[wr_ptr] <= lookup_pred;
        end
    end

    // consumer never returns more than it was given
    a_credit_max: assert property (
        @(posedge clk) disable iff (!arst_n)
        cred <= btb_pkg::pred_cred_t'(btb_pkg::PRED_CREDITS)
    ) else $error("prediction credit counter above its initial value");

    // a landing lookup always finds its reserved slot
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        lookup_valid |-> (int'(count) < btb_pkg::PRED_QUEUE_DEPTH)
    ) else $error("prediction queue overflow");

endmodule

`default_nettype wire

/* btb_top.sv */
`default_nettype none
`timescale 1ns/1ps

module btb_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  btb_pkg::btb_req_t    req,
    output logic                 req_credit,
    input  logic                 upd_valid,
    input  btb_pkg::btb_update_t upd,
    output logic                 pred_valid,
    output btb_pkg::btb_pred_t   pred,
    input  logic                 pred_credit
);

    logic               slot_free;     // output side can take one more answer
    logic               issue_valid;
    btb_pkg::btb_req_t  issue_req;
    logic               lookup_valid;
    btb_pkg::btb_pred_t lookup_pred;

    btb_req_queue u_req_queue (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .slot_free   (slot_free),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .req_credit  (req_credit)
    );

    btb_array u_array (
        .clk          (clk),
        .arst_n       (arst_n),
        .upd_valid    (upd_valid),
        .upd          (upd),
        .issue_valid  (issue_valid),
        .issue_req    (issue_req),
        .lookup_valid (lookup_valid),
        .lookup_pred  (lookup_pred)
    );

    btb_pred_out u_pred_out (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .lookup_valid (lookup_valid),
        .lookup_pred  (lookup_pred),
        .slot_free    (slot_free),
        .pred_valid   (pred_valid),
        .pred         (pred),
        .pred_credit  (pred_credit)
    );

endmodule

`default_nettype wire

/* tb_btb.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_btb;

    localparam string PATTERN_FILE = "btb_patterns.txt";

    logic                 clk;
    logic                 arst_n;
    logic                 req_valid;
    btb_pkg::btb_req_t    req;
    logic                 req_credit;
    logic                 upd_valid;
    btb_pkg::btb_update_t upd;
    logic                 pred_valid;
    btb_pkg::btb_pred_t   pred;
    logic                 pred_credit;

    btb_pkg::btb_pred_t exp_q [$];  // expected predictions in request order
    int due_q [$];                  // cycle at which each held credit may go back
    int seed;
    int errors;
    int checks;
    int cycle;
    int n_lines;
    bit lines_counted;
    int req_cred;                   // fetch credits on hand
    int pred_seen;
    int cred_returned;
    int stall;                      // cycles left with credits held back
    int stall_preds;
    int lookups;

    btb_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .upd_valid   (upd_valid),
        .upd         (upd),
        .pred_valid  (pred_valid),
        .pred        (pred),
        .pred_credit (pred_credit)
    );

    always #50 clk = ~clk;

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        checks++;
        assert (actv == expv) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expv, actv);
            errors++;
        end
    endtask

    // one clock step, strobes drop and a due credit may go back
    task automatic next_cycle();
        @(posedge clk);
        #5;
        cycle++;
        req_valid   = 1'b0;
        upd_valid   = 1'b0;
        pred_credit = 1'b0;
        if (stall > 0) begin
            stall--;
        end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            pred_credit = 1'b1;
        end
    endtask

    task automatic run_patterns(input int fd);
        logic [7:0]         kind;
        logic [8*128-1:0]   line_buf;
        btb_pkg::eip_t      eip;
        btb_pkg::eip_t      tgt;
        btb_pkg::eip_t      fe;
        btb_pkg::eip_t      fo;
        logic               hit;
        int                 n;
        btb_pkg::btb_pred_t e;
        while ($fscanf(fd, "%s", kind) == 1) begin
            case (kind)
                "#": void'($fgets(line_buf, fd));  // column notes
                "U": begin
                    n = $fscanf(fd, "%h %h %h %h", eip, tgt, fe, fo);
                    if (n != 4) begin
                        $display("malformed update line in %s", PATTERN_FILE);
                        errors++;
                    end
                    next_cycle();
                    upd_valid  = 1'b1;
                    upd.eip    = eip;
                    upd.target = tgt;
                    upd.fip_e  = fe;
                    upd.fip_o  = fo;
                end
                "L": begin
                    n = $fscanf(fd, "%h %h %h %h %h", eip, hit, tgt, fe, fo);
                    if (n != 5) begin
                        $display("malformed lookup line in %s", PATTERN_FILE);
                        errors++;
                    end
                    e.hit    = hit;
                    e.target = tgt;
                    e.fip_e  = fe[btb_pkg::FIP_W-1:0];  // file holds the 28-bit value
                    e.fip_o  = fo[btb_pkg::FIP_W-1:0];
                    next_cycle();
                    while (req_cred == 0) begin
                        next_cycle();
                    end
                    req_valid = 1'b1;
                    req.eip   = eip;
                    req_cred--;
                    exp_q.push_back(e);
                    lookups++;
                end
                "W": begin
                    while (exp_q.size() > 0) begin
                        next_cycle();
                    end
                end
                "S": begin
                    n = $fscanf(fd, "%d", stall);
                    stall_preds = 0;
                end
                default: begin
                    $display("unknown line kind in %s", PATTERN_FILE);
                    errors++;
                end
            endcase
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        btb_pkg::btb_pred_t e;
        if (arst_n) begin
            if (req_credit) begin
                req_cred++;
            end
            if (pred_valid) begin
                pred_seen++;
                checks++;
                assert (pred_seen <= cred_returned + btb_pkg::PRED_CREDITS) else begin
                    $display("prediction sent without a credit at %0t", $time);
                    errors++;
                end
                if (stall > 0) begin
                    stall_preds++;
                    checks++;
                    assert (stall_preds <= btb_pkg::PRED_CREDITS) else begin
                        $display("too many predictions while credits are held at %0t", $time);
                        errors++;
                    end
                end
                checks++;
                assert (exp_q.size() > 0) else begin
                    $display("prediction with no lookup pending at %0t", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    compare_field("pred.hit", 32'(e.hit), 32'(pred.hit));
                    compare_field("pred.target", e.target, pred.target);
                    compare_field("pred.fip_e", 32'(e.fip_e), 32'(pred.fip_e));
                    compare_field("pred.fip_o", 32'(e.fip_o), 32'(pred.fip_o));
                end
                due_q.push_back(cycle + int'($unsigned($random(seed)) % 4));  // 0 to 3 cycles
            end
            if (pred_credit) begin
                cred_returned++;
            end
        end
    end

    initial begin : main
        int fd;
        logic [8*128-1:0] line_buf;
        clk         = 1'b0;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        upd_valid   = 1'b0;
        upd         = '0;
        pred_credit = 1'b0;
        seed        = 24;
        req_cred    = btb_pkg::REQ_QUEUE_DEPTH;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            errors++;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            lines_counted = 1'b1;
            fd = $fopen(PATTERN_FILE, "r");
            repeat (16) @(posedge clk);
            #5;
            arst_n = 1'b1;
            run_patterns(fd);
            $fclose(fd);
            while (exp_q.size() > 0) begin
                next_cycle();
            end
            checks += 2;
            assert (pred_seen == lookups) else begin
                $display("%0d lookups sent but %0d predictions seen", lookups, pred_seen);
                errors++;
            end
            assert (req_cred == btb_pkg::REQ_QUEUE_DEPTH) else begin
                $display("request credits not all returned, %0d on hand", req_cred);
                errors++;
            end
        end
        $display("checks %0d, predictions %0d, errors %0d", checks, pred_seen, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (lines_counted);
        repeat (n_lines * 40 + 200) @(posedge clk);
        $display("timeout after %0d cycles, predictions still missing", n_lines * 40 + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* btb_patterns.txt */
# U eip target fip_e fip_o | L eip hit target fip_e fip_o, lookup fip is the upper 28 bits
# W waits for all predictions | S n holds back prediction credits for n cycles
L 00401000 0 00000000 0000000 0000000
L 00401005 0 00000000 0000000 0000000
L fffffffc 0 00000000 0000000 0000000
W
U 00401005 00402340 00401000 00401010
U 0040103a 0040ff00 a0000004 b000000c
L 00401005 1 00402340 0040100 0040101
L 0040103a 1 0040ff00 a000000 b000000
L 00401045 0 00000000 0000000 0000000
L 0040103b 0 00000000 0000000 0000000
W
U 00401045 00500000 12345678 9abcdef0
L 00401005 0 00000000 0000000 0000000
L 00401045 1 00500000 1234567 9abcdef
S 20
L 0040103a 1 0040ff00 a000000 b000000
L 00401045 1 00500000 1234567 9abcdef
L 00401000 0 00000000 0000000 0000000
L 00401045 1 00500000 1234567 9abcdef
L 0040103a 1 0040ff00 a000000 b000000
L 00401001 0 00000000 0000000 0000000
L 00401005 0 00000000 0000000 0000000
W
U 00401005 80001000 fedcba98 01234567
L 00401005 1 80001000 fedcba9 0123456
L 00401045 0 00000000 0000000 0000000
S 8
L 0040103a 1 0040ff00 a000000 b000000
W

/* all.f */
btb_pkg.sv
btb_req_queue.sv
btb_array.sv
btb_pred_out.sv
btb_top.sv
tb_btb.sv

/* run_sim.sh */
#!/bin/sh
# build the BTB testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_btb \
    -f all.f -o tb_btb > sim.log 2>&1 \
    && ./obj_dir/tb_btb >> sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1
